//--- cam_bist_consts.svh
// Geometry and flow-control constants for the CAM MBIST path
// Include in any file that sizes storage, addresses or the command buffer

`ifndef CAM_BIST_CONSTS_SVH
`define CAM_BIST_CONSTS_SVH

// ==================================================
// Array geometry
// ==================================================

// Number of CAM entries
// Not a multiple of the data width, so the fold has a remainder group
`define CAM_ENTRIES 20

// Entry, search key and read data width
`define CAM_DWIDTH 8

// Address width, wide enough for all entries
`define CAM_AWIDTH 5

// Command buffer depth, also the sender's starting credit count
`define CAM_BIST_CREDITS 4

`endif

//--- cam_bist_pkg.sv
// Shared types for the CAM MBIST path
// Opcodes, match selects, decode states and the structs passed between stages

`default_nettype none

`include "cam_bist_consts.svh"

package cam_bist_pkg;

  // Command and array opcodes
  // OP_FILL only appears on commands, decode expands it into writes
  typedef enum logic [2:0] {
    OP_NOP    = 3'd0,
    OP_WRITE  = 3'd1,
    OP_READ   = 3'd2,
    OP_SEARCH = 3'd3,
    OP_FILL   = 3'd4
  } cam_op_e;

  // Expected match pattern select
  typedef enum logic [1:0] {
    SEL_ALL_MATCH       = 2'd0,
    SEL_SINGLE_MATCH    = 2'd1,
    SEL_SINGLE_MISMATCH = 2'd2,
    SEL_ALL_MISMATCH    = 2'd3
  } match_sel_e;

  // Decode issue FSM
  typedef enum logic {
    DEC_IDLE = 1'b0,
    DEC_FILL = 1'b1
  } dec_state_e;

  // Command from the test sequencer
  // data is write data for writes and fills, the key for searches
  typedef struct packed {
    cam_op_e                 op;
    logic [`CAM_AWIDTH-1:0]  addr;
    logic [`CAM_DWIDTH-1:0]  data;
    match_sel_e              match_sel;
  } cam_cmd_t;

  // Single array operation, match_sel rides along to the output handler
  typedef struct packed {
    cam_op_e                 op;
    logic [`CAM_AWIDTH-1:0]  addr;
    logic [`CAM_DWIDTH-1:0]  data;
    match_sel_e              match_sel;
  } cam_arr_op_t;

  // Result word sampled by the tester
  typedef struct packed {
    logic                    search;
    logic [`CAM_DWIDTH-1:0]  data;
    logic                    miscompare;
  } cam_result_t;

endpackage

`default_nettype wire

//--- cam_bist_decode.sv
// Command decode for the CAM MBIST path
// Buffers sequencer commands under credit flow control and issues one
// array operation per cycle; fills expand into a run of writes

`timescale 1ns/1ps
`default_nettype none

`include "cam_bist_consts.svh"

module cam_bist_decode
  import cam_bist_pkg::*;
(
  input  wire logic        bist_clk,
  input  wire logic        rst_n,
  input  wire logic        cmd_valid,
  input  wire cam_cmd_t    cmd,
  output logic             cmd_credit,
  output cam_arr_op_t      arr_op
);

  localparam int PTR_W = (`CAM_BIST_CREDITS > 1) ? $clog2(`CAM_BIST_CREDITS) : 1;
  localparam int CNT_W = $clog2(`CAM_BIST_CREDITS + 1);
  localparam logic [`CAM_AWIDTH-1:0] LAST_ADDR = `CAM_AWIDTH'(`CAM_ENTRIES - 1);

  cam_cmd_t                cmd_buf [`CAM_BIST_CREDITS];
  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  logic [CNT_W-1:0]        count;
  cam_cmd_t                head;
  dec_state_e              state;
  dec_state_e              state_nxt;
  logic [`CAM_AWIDTH-1:0]  fill_addr;
  logic [`CAM_AWIDTH-1:0]  fill_nxt;
  logic                    pop;
  cam_arr_op_t             issue;

  // Circular pointer advance
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`CAM_BIST_CREDITS - 1)) begin
      next_ptr = '0;
    end else begin
      next_ptr = ptr + PTR_W'(1);
    end
  endfunction

  // ==================================================
  // Command buffer
  // ==================================================

  // Storage only, no overflow check since the sender owns the credits
  always_ff @(posedge bist_clk) begin
    if (cmd_valid) begin
      cmd_buf[wr_ptr] <= cmd;
    end
  end

  assign head = cmd_buf[rd_ptr];

  // ==================================================
  // Issue FSM
  // ==================================================

  always_comb begin
    pop       = 1'b0;
    state_nxt = state;
    fill_nxt  = fill_addr;
    issue     = '{op: OP_NOP, match_sel: SEL_ALL_MATCH, default: '0};
    case (state)
      DEC_IDLE: begin
        if (count != '0) begin
          if (head.op == OP_FILL) begin
            // First fill write goes out at once, fill_addr rests at zero here
            issue = '{op: OP_WRITE, addr: fill_addr, data: head.data,
                      match_sel: head.match_sel};
            if (fill_addr == LAST_ADDR) begin
              pop = 1'b1;
            end else begin
              state_nxt = DEC_FILL;
              fill_nxt  = fill_addr + `CAM_AWIDTH'(1);
            end
          end else begin
            issue = '{op: head.op, addr: head.addr, data: head.data,
                      match_sel: head.match_sel};
            pop   = 1'b1;
          end
        end
      end
      DEC_FILL: begin
        // Head stays the fill command until its last write
        issue = '{op: OP_WRITE, addr: fill_addr, data: head.data,
                  match_sel: head.match_sel};
        if (fill_addr == LAST_ADDR) begin
          pop       = 1'b1;
          state_nxt = DEC_IDLE;
          fill_nxt  = '0;
        end else begin
          fill_nxt = fill_addr + `CAM_AWIDTH'(1);
        end
      end
      default: begin
        state_nxt = DEC_IDLE;
        fill_nxt  = '0;
      end
    endcase
  end

  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      state      <= DEC_IDLE;
      fill_addr  <= '0;
      cmd_credit <= 1'b0;
      arr_op     <= '{op: OP_NOP, match_sel: SEL_ALL_MATCH, default: '0};
    end else begin
      if (cmd_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count      <= count + CNT_W'(cmd_valid) - CNT_W'(pop);
      state      <= state_nxt;
      fill_addr  <= fill_nxt;
      // One credit back per command leaving the buffer
      cmd_credit <= pop;
      arr_op     <= issue;
    end
  end

endmodule

`default_nettype wire

//--- cam_array.sv
// Behavioral CAM array for the MBIST path
// One operation per cycle: write, read or parallel key search
// Read data and match lines are registered, one cycle after the operation

`timescale 1ns/1ps
`default_nettype none

`include "cam_bist_consts.svh"

module cam_array
  import cam_bist_pkg::*;
(
  input  wire logic                      bist_clk,
  input  wire cam_arr_op_t               arr_op,
  output logic [`CAM_DWIDTH-1:0]         rd_data,
  output logic [`CAM_ENTRIES-1:0]        match_lines
);

  // ==================================================
  // Storage
  // ==================================================

  // Entries by width, contents unknown until written
  logic [`CAM_DWIDTH-1:0]  mem [`CAM_ENTRIES];
  logic                    addr_ok;
  logic [`CAM_ENTRIES-1:0] hit;

  // Addresses above the last entry are ignored
  assign addr_ok = int'(arr_op.addr) < `CAM_ENTRIES;

  // Write port
  always_ff @(posedge bist_clk) begin
    if (arr_op.op == OP_WRITE && addr_ok) begin
      mem[arr_op.addr] <= arr_op.data;
    end
  end

  // Read port
  // rd_data holds its value between reads
  always_ff @(posedge bist_clk) begin
    if (arr_op.op == OP_READ) begin
      if (addr_ok) begin
        rd_data <= mem[arr_op.addr];
      end else begin
        rd_data <= '0;
      end
    end
  end

  // ==================================================
  // Search
  // ==================================================

  // One comparator per entry against the key
  always_comb begin
    for (int i = 0; i < `CAM_ENTRIES; i++) begin
      hit[i] = (mem[i] == arr_op.data);
    end
  end

  // Match lines only update on a search, otherwise keep the last result
  always_ff @(posedge bist_clk) begin
    if (arr_op.op == OP_SEARCH) begin
      match_lines <= hit;
    end
  end

endmodule

`default_nettype wire

//--- cam_bist_outhandler.sv
// MBIST output handler for the CAM
// Builds the expected match vector, compares it with the match lines,
// folds the mismatch to the data width and muxes it onto the result
// in search mode; keeps a sticky fail flag for any miscompare

`timescale 1ns/1ps
`default_nettype none

`include "cam_bist_consts.svh"

module cam_bist_outhandler
  import cam_bist_pkg::*;
#(
  parameter int ENTRIES = `CAM_ENTRIES,
  parameter int DWIDTH  = `CAM_DWIDTH,
  parameter int AWIDTH  = `CAM_AWIDTH
) (
  input  wire logic                bist_clk,
  input  wire logic                rst_n,
  input  wire cam_arr_op_t         arr_op,
  input  wire logic [DWIDTH-1:0]   rd_data,
  input  wire logic [ENTRIES-1:0]  match_lines,
  output logic                     res_valid,
  output cam_result_t              res,
  output logic                     bist_fail
);

  cam_op_e              op_2d;
  logic [AWIDTH-1:0]    addr_2d;
  match_sel_e           sel_2d;
  logic [ENTRIES-1:0]   single_match;
  logic [ENTRIES-1:0]   exp_match;
  logic [ENTRIES-1:0]   mismatch;
  logic [DWIDTH-1:0]    fold;
  logic                 is_search;
  logic                 is_read;
  logic                 fold_err;

  // ==================================================
  // Operation delay chain
  // ==================================================

  // arr_op from decode is stage one; this register is stage two and
  // lines up with rd_data and match_lines from the array
  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      op_2d <= OP_NOP;
    end else begin
      op_2d <= arr_op.op;
    end
  end

  always_ff @(posedge bist_clk) begin
    addr_2d <= arr_op.addr[AWIDTH-1:0];
    sel_2d  <= arr_op.match_sel;
  end

  // ==================================================
  // Expected match and compare
  // ==================================================

  // One-hot at the tested entry
  assign single_match = ENTRIES'(1) << addr_2d;

  always_comb begin
    case (sel_2d)
      SEL_ALL_MATCH:       exp_match = '1;
      SEL_SINGLE_MATCH:    exp_match = single_match;
      SEL_SINGLE_MISMATCH: exp_match = ~single_match;
      SEL_ALL_MISMATCH:    exp_match = '0;
      default:             exp_match = '0;
    endcase
  end

  // A set bit marks an entry that disagrees with the pattern
  assign mismatch = exp_match ^ match_lines;

  // ==================================================
  // Fold to data width
  // ==================================================

  if (DWIDTH < ENTRIES) begin : g_compact
    localparam int GROUPS = ENTRIES / DWIDTH;
    localparam int REM    = ENTRIES % DWIDTH;
    logic [DWIDTH-1:0] whole;
    // Column j ORs bits j, j+DWIDTH, ... of the whole groups
    for (genvar j = 0; j < DWIDTH; j++) begin : g_col
      logic [GROUPS-1:0] col;
      for (genvar g = 0; g < GROUPS; g++) begin : g_grp
        assign col[g] = mismatch[j + g * DWIDTH];
      end
      assign whole[j] = |col;
    end
    if (REM != 0) begin : g_rem
      // Leftover top entries land on the top folded bits in order
      assign fold = whole | {mismatch[ENTRIES-1 -: REM], {(DWIDTH - REM){1'b0}}};
    end else begin : g_norem
      assign fold = whole;
    end
  end else if (DWIDTH == ENTRIES) begin : g_equal
    assign fold = mismatch;
  end else begin : g_expand
    // Left aligned, low bits padded with zeros
    assign fold = {mismatch, {(DWIDTH - ENTRIES){1'b0}}};
  end

  // ==================================================
  // Output mux and fail flag
  // ==================================================

  assign is_search = (op_2d == OP_SEARCH);
  assign is_read   = (op_2d == OP_READ);
  assign fold_err  = is_search && (|fold);

  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
      bist_fail <= 1'b0;
    end else begin
      // Writes and idle cycles produce no result
      res_valid <= is_search || is_read;
      bist_fail <= bist_fail || fold_err;
    end
  end

  // Search replaces read data with the folded mismatch
  always_ff @(posedge bist_clk) begin
    res.search     <= is_search;
    res.data       <= is_search ? fold : rd_data;
    res.miscompare <= fold_err;
  end

endmodule

`default_nettype wire

//--- cam_bist_top.sv
// Top level of the CAM MBIST path
// Sequencer commands in through decode, through the CAM array,
// results and the sticky fail flag out of the output handler

`timescale 1ns/1ps
`default_nettype none

`include "cam_bist_consts.svh"

module cam_bist_top
  import cam_bist_pkg::*;
(
  input  wire logic        bist_clk,
  input  wire logic        rst_n,
  input  wire logic        cmd_valid,
  input  wire cam_cmd_t    cmd,
  output logic             cmd_credit,
  output logic             res_valid,
  output cam_result_t      res,
  output logic             bist_fail
);

  // Decode to array and handler
  cam_arr_op_t               arr_op;
  // Array to handler
  logic [`CAM_DWIDTH-1:0]    rd_data;
  logic [`CAM_ENTRIES-1:0]   match_lines;

  // Command buffer and op issue
  cam_bist_decode u_decode (
    .bist_clk   (bist_clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_credit (cmd_credit),
    .arr_op     (arr_op)
  );

  cam_array u_array (
    .bist_clk    (bist_clk),
    .arr_op      (arr_op),
    .rd_data     (rd_data),
    .match_lines (match_lines)
  );

  // Compare, fold and result
  cam_bist_outhandler #(
    .ENTRIES (`CAM_ENTRIES),
    .DWIDTH  (`CAM_DWIDTH),
    .AWIDTH  (`CAM_AWIDTH)
  ) u_outhandler (
    .bist_clk    (bist_clk),
    .rst_n       (rst_n),
    .arr_op      (arr_op),
    .rd_data     (rd_data),
    .match_lines (match_lines),
    .res_valid   (res_valid),
    .res         (res),
    .bist_fail   (bist_fail)
  );

endmodule

`default_nettype wire

//--- tb_cam_bist.sv
// Testbench for the CAM MBIST path
// Sends credit-controlled commands into cam_bist_top and predicts each result
// from a shadow array; results are compared in command order as they arrive

`timescale 1ns/1ps
`default_nettype none

`include "cam_bist_consts.svh"

module tb_cam_bist
  import cam_bist_pkg::*;
();

  localparam int ENTRIES = `CAM_ENTRIES;
  localparam int DW      = `CAM_DWIDTH;
  localparam int CREDITS = `CAM_BIST_CREDITS;
  localparam int TIMEOUT = 500;

  logic         bist_clk;
  logic         rst_n;
  logic         cmd_valid;
  cam_cmd_t     cmd;
  logic         cmd_credit;
  logic         res_valid;
  cam_result_t  res;
  logic         bist_fail;

  // Model state
  logic [DW-1:0] shadow [ENTRIES];
  cam_result_t   exp_q [$];
  cam_result_t   exp_res;
  logic          model_fail = 1'b0;
  int            sent       = 0;
  int            returned   = 0;
  int            got        = 0;

  cam_bist_top dut0 (
    .bist_clk   (bist_clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_credit (cmd_credit),
    .res_valid  (res_valid),
    .res        (res),
    .bist_fail  (bist_fail)
  );

  initial begin
    bist_clk = 1'b0;
    forever #5 bist_clk = ~bist_clk;
  end

  // ==================================================
  // Checks and reference model
  // ==================================================

  task automatic check_val(input logic [31:0] got_v, input logic [31:0] exp_v,
                           input string what);
    if (got_v !== exp_v) begin
      $display("[ERROR] %0t ns: %s got 'h%0h expected 'h%0h", $time, what, got_v, exp_v);
      $display("TB FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic timeout_stop(input string what);
    $display("Timeout at %0t ns, %s", $time, what);
    $display("TB FAILED");
    $fatal(1, "Stopped on timeout");
  endtask

  // Expected result of a read or search against the shadow array
  function automatic cam_result_t ref_result(input cam_cmd_t c);
    cam_result_t          r;
    logic [ENTRIES-1:0]   lines;
    logic [ENTRIES-1:0]   expv;
    logic [ENTRIES-1:0]   mm;
    logic [DW-1:0]        fold;
    int                   groups;
    int                   rem;
    r      = '0;
    groups = ENTRIES / DW;
    rem    = ENTRIES % DW;
    if (c.op == OP_READ) begin
      r.data = shadow[c.addr];
    end else begin
      for (int i = 0; i < ENTRIES; i++) begin
        lines[i] = (shadow[i] == c.data);
        case (c.match_sel)
          SEL_ALL_MATCH:       expv[i] = 1'b1;
          SEL_SINGLE_MATCH:    expv[i] = (i == int'(c.addr));
          SEL_SINGLE_MISMATCH: expv[i] = (i != int'(c.addr));
          default:             expv[i] = 1'b0;
        endcase
      end
      mm   = lines ^ expv;
      fold = '0;
      // Whole groups OR column-wise
      for (int i = 0; i < groups * DW; i++) begin
        fold[i % DW] = fold[i % DW] | mm[i];
      end
      // Leftover entries go to the top bits, lowest leftover first
      for (int k = 0; k < rem; k++) begin
        fold[DW - rem + k] = fold[DW - rem + k] | mm[groups * DW + k];
      end
      r.search     = 1'b1;
      r.data       = fold;
      r.miscompare = |fold;
    end
    return r;
  endfunction

  function automatic cam_cmd_t make_cmd(input cam_op_e op, input logic [`CAM_AWIDTH-1:0] addr,
                                        input logic [DW-1:0] data, input match_sel_e sel);
    cam_cmd_t c;
    c.op        = op;
    c.addr      = addr;
    c.data      = data;
    c.match_sel = sel;
    return c;
  endfunction

  // Shadow array follows command order, so predictions queue in result order
  task automatic apply_to_model(input cam_cmd_t c);
    cam_result_t r;
    case (c.op)
      OP_WRITE: shadow[c.addr] = c.data;
      OP_FILL: begin
        for (int i = 0; i < ENTRIES; i++) begin
          shadow[i] = c.data;
        end
      end
      OP_READ, OP_SEARCH: begin
        r = ref_result(c);
        exp_q.push_back(r);
        model_fail = model_fail | r.miscompare;
      end
      default: ;
    endcase
  endtask

  // ==================================================
  // Driver
  // ==================================================

  // One command per falling edge, only while a credit is held
  task automatic send_cmd(input cam_cmd_t c);
    int waited;
    waited = 0;
    @(negedge bist_clk);
    cmd_valid = 1'b0;
    while (CREDITS + returned - sent <= 0) begin
      if (waited >= TIMEOUT) begin
        timeout_stop("no command credit came back");
      end else begin
        @(negedge bist_clk);
        waited++;
      end
    end
    cmd       = c;
    cmd_valid = 1'b1;
    sent++;
    apply_to_model(c);
  endtask

  // Idle the command port until every predicted result has come back
  task automatic drain_results();
    int waited;
    waited = 0;
    @(negedge bist_clk);
    cmd_valid = 1'b0;
    while (exp_q.size() != 0) begin
      if (waited >= TIMEOUT) begin
        timeout_stop("results still outstanding");
      end else begin
        @(negedge bist_clk);
        waited++;
      end
    end
  endtask

  // Credit pulses counted on the rising edge, never more than were spent
  always @(posedge bist_clk) begin
    if (rst_n && cmd_credit) begin
      returned++;
      check_val(returned <= sent, 1, "credit returned with no command outstanding");
    end
  end

  // ==================================================
  // Result compare
  // ==================================================

  always @(negedge bist_clk) begin
    if (rst_n && res_valid) begin
      check_val(exp_q.size() > 0, 1, "result with an empty expectation queue");
      exp_res = exp_q.pop_front();
      check_val(res, exp_res, $sformatf("result %0d", got));
      got++;
    end
  end

  // ==================================================
  // Stimulus
  // ==================================================

  initial begin
    logic [`CAM_AWIDTH-1:0] addrs [8];
    logic [`CAM_AWIDTH-1:0] a;
    logic [DW-1:0]          d;
    cam_cmd_t               c;
    cam_result_t            pred;
    int                     waited;
    int                     pick;
    void'($urandom(13396));
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    repeat (4) @(posedge bist_clk);
    @(negedge bist_clk);
    rst_n = 1'b1;
    check_val(cmd_credit, 0, "cmd_credit after reset");
    check_val(res_valid, 0, "res_valid after reset");
    check_val(bist_fail, 0, "bist_fail after reset");

    // Write and read back
    send_cmd(make_cmd(OP_FILL, 0, 8'h00, SEL_ALL_MATCH));
    for (int i = 0; i < 8; i++) begin
      addrs[i] = `CAM_AWIDTH'($urandom_range(ENTRIES - 1));
      send_cmd(make_cmd(OP_WRITE, addrs[i], DW'($urandom), SEL_ALL_MATCH));
    end
    for (int i = 0; i < 8; i++) begin
      send_cmd(make_cmd(OP_READ, addrs[i], 8'h00, SEL_ALL_MATCH));
    end

    // Single match on a background, key restored after each probe
    send_cmd(make_cmd(OP_FILL, 0, 8'h5A, SEL_ALL_MATCH));
    for (int k = 0; k < 3; k++) begin
      a = `CAM_AWIDTH'(3 + 7 * k);
      send_cmd(make_cmd(OP_WRITE, a, 8'hC3, SEL_ALL_MATCH));
      c    = make_cmd(OP_SEARCH, a, 8'hC3, SEL_SINGLE_MATCH);
      pred = ref_result(c);
      check_val(pred.data, 0, "model single match fold");
      send_cmd(c);
      send_cmd(make_cmd(OP_WRITE, a, 8'h5A, SEL_ALL_MATCH));
    end

    // All-match and all-mismatch
    send_cmd(make_cmd(OP_FILL, 0, 8'h3C, SEL_ALL_MATCH));
    send_cmd(make_cmd(OP_SEARCH, 0, 8'h3C, SEL_ALL_MATCH));
    send_cmd(make_cmd(OP_SEARCH, 0, 8'hC3, SEL_ALL_MISMATCH));

    // No miscompare so far, the fail flag is still low
    drain_results();
    check_val(bist_fail, model_fail, "bist_fail before deliberate miscompares");

    // Deliberate miscompares, entry 17 folds onto data bit 5
    c    = make_cmd(OP_SEARCH, 0, 8'h3C, SEL_ALL_MISMATCH);
    pred = ref_result(c);
    check_val(pred.data, 8'hFF, "model all-mismatch fold");
    send_cmd(c);
    send_cmd(make_cmd(OP_WRITE, 17, 8'h99, SEL_ALL_MATCH));
    c    = make_cmd(OP_SEARCH, 2, 8'h99, SEL_SINGLE_MATCH);
    pred = ref_result(c);
    check_val(pred.data, 8'h24, "model wrong-address fold");
    send_cmd(c);
    c    = make_cmd(OP_SEARCH, 9, 8'h99, SEL_SINGLE_MATCH);
    pred = ref_result(c);
    check_val(pred.data, 8'h22, "model group and remainder fold");
    send_cmd(c);
    send_cmd(make_cmd(OP_SEARCH, 17, 8'h3C, SEL_SINGLE_MISMATCH));

    // Random back-to-back mix with fills
    for (int i = 0; i < 40; i++) begin
      pick = $urandom_range(9);
      a    = `CAM_AWIDTH'($urandom_range(ENTRIES - 1));
      d    = $urandom_range(1) ? shadow[$urandom_range(ENTRIES - 1)] : DW'($urandom);
      if (pick == 0) begin
        send_cmd(make_cmd(OP_FILL, 0, d, SEL_ALL_MATCH));
      end else if (pick <= 3) begin
        send_cmd(make_cmd(OP_WRITE, a, d, SEL_ALL_MATCH));
      end else if (pick <= 6) begin
        send_cmd(make_cmd(OP_READ, a, d, SEL_ALL_MATCH));
      end else begin
        send_cmd(make_cmd(OP_SEARCH, a, d, match_sel_e'($urandom_range(3))));
      end
    end

    // Drain results, then wait for the last fill's credit
    drain_results();
    waited = 0;
    while (returned != sent) begin
      if (waited >= TIMEOUT) begin
        timeout_stop("credits still outstanding");
      end else begin
        @(negedge bist_clk);
        waited++;
      end
    end
    @(negedge bist_clk);
    check_val(bist_fail, model_fail, "sticky bist_fail");
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
cam_bist_pkg.sv
cam_bist_decode.sv
cam_array.sv
cam_bist_outhandler.sv
cam_bist_top.sv
tb_cam_bist.sv

//--- Bender.yml
package:
  name: cam_bist

# Consts header lives in the project root
export_include_dirs:
  - .

sources:
  # Design, in compile order
  - files:
      - cam_bist_pkg.sv
      - cam_bist_decode.sv
      - cam_array.sv
      - cam_bist_outhandler.sv
      - cam_bist_top.sv
  # Testbench
  - target: test
    files:
      - tb_cam_bist.sv
